/* Bender.yml */
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - csr_decode.sv
  - csr_trap_ctrl.sv
  - csr_regfile.sv
  - csr_unit.sv
  - target: test
    files:
      - csr_tb.sv

/* csr_decode.sv */
`timescale 1ns/1ps

module csr_decode (
	input  logic                i_csr_en,     // Pipeline says system opcode
	input  logic [31:0]         i_inst,
	output logic                o_csr_access,
	output csr_pkg::csr_op_e    o_csr_op,
	output csr_pkg::csr_addr_t  o_csr_addr,
	output logic                o_is_ecall,
	output logic                o_is_ebreak,
	output logic                o_is_mret,
	output logic                o_illegal_csr
);
	import csr_pkg::*;

	logic [2:0] funct3;
	csr_addr_t  funct12;
	logic [4:0] rs1;       // Register index or zimm
	logic       is_priv;   // funct3 == 000 under enable
	logic       is_csr;    // Any Zicsr form
	logic       implemented;
	logic       read_only;
	logic       writes;    // Access changes the register

	// Instruction fields
	assign funct3  = i_inst[14:12];
	assign funct12 = i_inst[31:20];
	assign rs1     = i_inst[19:15];

	assign is_priv = i_csr_en && (funct3 == F3_PRIV);
	// funct3[2] only picks the immediate form since the operand comes in ready
	assign is_csr  = i_csr_en && (funct3[1:0] != 2'b00);

	assign o_csr_access = is_csr;
	assign o_csr_op     = is_csr ? csr_op_e'(funct3[1:0]) : CSR_NONE;
	assign o_csr_addr   = funct12;

	// System instructions told apart by funct12
	assign o_is_ecall  = is_priv && (funct12 == F12_ECALL);
	assign o_is_ebreak = is_priv && (funct12 == F12_EBREAK);
	assign o_is_mret   = is_priv && (funct12 == ADDR_MRET);

	// Address check against the implemented set
	always_comb begin
		implemented = 1'b0;
		read_only   = 1'b0;
		case (funct12)
			ADDR_MHARTID,
			ADDR_MISA,
			ADDR_MIP: begin
				implemented = 1'b1;
				read_only   = 1'b1; // Writes trap
			end
			ADDR_MSTATUS,
			ADDR_MEDELEG,
			ADDR_MIE,
			ADDR_MTVEC,
			ADDR_MSCRATCH,
			ADDR_MEPC,
			ADDR_MCAUSE,
			ADDR_MTVAL: implemented = 1'b1;
			default: implemented = 1'b0;
		endcase
	end

	// CSRRS/CSRRC with x0 or zimm 0 only read
	assign writes = (o_csr_op == CSR_RW) || (rs1 != 5'd0);

	assign o_illegal_csr = is_csr && (!implemented || (read_only && writes));

endmodule

/* csr_pkg.sv */
package csr_pkg;

	// Data width of the hart
	localparam int XLEN = 32;

	// Machine word, used for data, PC and CSR contents
	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [11:0]     csr_addr_t; // CSR address field
	typedef logic [4:0]      cause_t;    // Exception/interrupt code, int flag kept apart

	// CSR operation, taken from funct3[1:0]
	typedef enum logic [1:0] {
		CSR_NONE = 2'b00,
		CSR_RW   = 2'b01, // Write operand
		CSR_RS   = 2'b10, // Set bits
		CSR_RC   = 2'b11  // Clear bits
	} csr_op_e;

	// Machine trap setup
	localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
	localparam csr_addr_t ADDR_MISA     = 12'h301;
	localparam csr_addr_t ADDR_MEDELEG  = 12'h302;
	localparam csr_addr_t ADDR_MIE      = 12'h304;
	localparam csr_addr_t ADDR_MTVEC    = 12'h305;

	// Machine trap handling
	localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
	localparam csr_addr_t ADDR_MEPC     = 12'h341;
	localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
	localparam csr_addr_t ADDR_MTVAL    = 12'h343;
	localparam csr_addr_t ADDR_MIP      = 12'h344;

	localparam csr_addr_t ADDR_MHARTID  = 12'hF14; // Machine info, read only

	// funct12 of the system instructions
	localparam csr_addr_t F12_ECALL     = 12'h000;
	localparam csr_addr_t F12_EBREAK    = 12'h001;
	localparam csr_addr_t ADDR_MRET     = 12'h302;

	localparam logic [2:0] F3_PRIV = 3'b000; // ECALL, EBREAK, xRET

	// Exception codes
	localparam cause_t CAUSE_INST_MISALIGN  = 5'd0;
	localparam cause_t CAUSE_ILLEGAL        = 5'd2;
	localparam cause_t CAUSE_BREAKPOINT     = 5'd3;
	localparam cause_t CAUSE_LOAD_MISALIGN  = 5'd4;
	localparam cause_t CAUSE_STORE_MISALIGN = 5'd6;
	localparam cause_t CAUSE_ECALL_M        = 5'd11;
	// Interrupt code, with mcause[XLEN-1] set
	localparam cause_t CAUSE_TIMER_INT      = 5'd7;

	// Bit positions in mstatus, mie and mip
	localparam int MSTATUS_MIE  = 3;
	localparam int MSTATUS_MPIE = 7;
	localparam int MSTATUS_MPP  = 11; // Low bit of the 2-bit field
	localparam int MIX_MT       = 7;  // MTIE / MTIP

	localparam logic [1:0] PRIV_M = 2'b11; // Only machine mode exists

	// MXL = 1 (32 bit), extension I
	localparam xlen_t MISA_VALUE = 32'h4000_0100;
	localparam xlen_t HART_ID    = 32'h0000_0000;

endpackage

/* csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile (
	input  logic                i_clk,
	input  logic                i_rst,          // Sync, active low
	input  logic                i_csr_access,
	input  csr_pkg::csr_op_e    i_csr_op,
	input  csr_pkg::csr_addr_t  i_csr_addr,
	input  csr_pkg::xlen_t      i_wd,           // rs1 value or zimm
	input  logic                i_is_mret,
	input  logic                i_int_tip,
	input  logic                i_trap,
	input  logic                i_trap_int,
	input  logic                i_sync_ex,
	input  csr_pkg::cause_t     i_trap_cause,
	input  csr_pkg::xlen_t      i_trap_tval,
	input  logic                i_tval_we,
	input  csr_pkg::xlen_t      i_trap_epc,
	output csr_pkg::xlen_t      o_rd,
	output logic                o_mstatus_mie,
	output logic                o_mtie,
	output csr_pkg::xlen_t      o_tvec,
	output csr_pkg::xlen_t      o_cause,
	output logic                o_eret,
	output csr_pkg::xlen_t      o_epc
);
	import csr_pkg::*;

	// mstatus stack and mie
	logic  mie;
	logic  mpie;
	logic  mtie;

	xlen_t mtvec;    // Direct mode only
	xlen_t mcause;
	xlen_t medeleg;  // Storage only without delegation
	xlen_t mscratch;
	xlen_t mepc;
	xlen_t mtval;

	xlen_t rd_val;   // Old value of the addressed CSR
	xlen_t wdata;
	logic  csr_we;

	// Read mux
	always_comb begin
		rd_val = '0;
		case (i_csr_addr)
			ADDR_MHARTID: rd_val = HART_ID;
			ADDR_MISA:    rd_val = MISA_VALUE;
			ADDR_MSTATUS: begin
				rd_val[MSTATUS_MIE]     = mie;
				rd_val[MSTATUS_MPIE]    = mpie;
				rd_val[MSTATUS_MPP +: 2] = PRIV_M; // MPP fixed to M
			end
			ADDR_MEDELEG:  rd_val = medeleg;
			ADDR_MIE:      rd_val[MIX_MT] = mtie;
			ADDR_MIP:      rd_val[MIX_MT] = i_int_tip; // Live pending bit
			ADDR_MTVEC:    rd_val = mtvec;
			ADDR_MSCRATCH: rd_val = mscratch;
			ADDR_MEPC:     rd_val = mepc;
			ADDR_MCAUSE:   rd_val = mcause;
			ADDR_MTVAL:    rd_val = mtval;
			default:       rd_val = '0;
		endcase
	end

	assign o_rd = rd_val;

	// Write data per operation
	always_comb begin
		case (i_csr_op)
			CSR_RW:  wdata = i_wd;
			CSR_RS:  wdata = rd_val | i_wd;
			CSR_RC:  wdata = rd_val & ~i_wd;
			default: wdata = rd_val;
		endcase
	end

	// Exception cancels the write, interrupt does not
	assign csr_we = i_csr_access && !i_sync_ex;

	// Control state
	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			mie    <= 1'b0; // Interrupts off
			mpie   <= 1'b0;
			mtie   <= 1'b0;
			mtvec  <= '0;
			mcause <= '0;
		end else begin
			if (csr_we) begin
				case (i_csr_addr)
					ADDR_MSTATUS: begin
						mie  <= wdata[MSTATUS_MIE];
						mpie <= wdata[MSTATUS_MPIE];
					end
					ADDR_MIE:    mtie   <= wdata[MIX_MT];
					ADDR_MTVEC:  mtvec  <= {wdata[XLEN-1:2], 2'b00}; // Mode ignored
					ADDR_MCAUSE: mcause <= wdata;
					default: ;
				endcase
			end
			// Trap pushes the stack and overrides any CSR write
			if (i_trap) begin
				mpie   <= mie;
				mie    <= 1'b0;
				mcause <= {i_trap_int, {(XLEN-6){1'b0}}, i_trap_cause};
			end else if (i_is_mret) begin
				mie  <= mpie; // Pop
				mpie <= 1'b1;
			end
		end
	end

	// Payload registers
	always_ff @(posedge i_clk) begin
		if (csr_we) begin
			case (i_csr_addr)
				ADDR_MEDELEG:  medeleg  <= wdata;
				ADDR_MSCRATCH: mscratch <= wdata;
				ADDR_MEPC:     mepc     <= {wdata[XLEN-1:2], 2'b00};
				ADDR_MTVAL:    mtval    <= wdata;
				default: ;
			endcase
		end
		if (i_trap) begin
			mepc <= i_trap_epc;
			if (i_tval_we)
				mtval <= i_trap_tval; // Interrupt keeps old mtval
		end
	end

	assign o_mstatus_mie = mie;
	assign o_mtie        = mtie;
	assign o_tvec        = mtvec;
	assign o_cause       = mcause;

	// MRET loses to a trap in the same cycle
	assign o_eret = i_is_mret && !i_trap;
	assign o_epc  = o_eret ? mepc : '0;

	// Timer trap only with both enables set and the timer pending
	a_int_enabled: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_trap_int |-> (mie && mtie && i_int_tip))
		else $error("csr_regfile: interrupt taken while masked");

	// Alignment of mepc once it holds a value
	a_mepc_align: assert property (@(posedge i_clk) disable iff (!i_rst)
		!$isunknown(mepc) |-> (mepc[1:0] == 2'b00))
		else $error("csr_regfile: mepc not word aligned");

endmodule

/* csr_tb.sv */
`timescale 1ns/1ps

module csr_tb;
	import csr_pkg::*;

	localparam int NUM_TESTS = 6;

	logic        i_clk;
	logic        i_rst;
	logic        i_csr_en;
	xlen_t       i_wd;
	logic [31:0] i_inst;
	xlen_t       i_pc;
	xlen_t       i_badaddr;
	logic        i_illegal;
	logic        i_ex_inst_addr;
	logic        i_ex_ld_addr;
	logic        i_ex_st_addr;
	logic        i_int_tip;
	xlen_t       o_rd;
	logic        o_ex;
	xlen_t       o_tvec;
	xlen_t       o_cause;
	logic        o_eret;
	xlen_t       o_epc;

	logic [31:0] rng;       // xorshift state
	logic        tip_level; // Timer pending level for the next drive
	int          n_checks;
	int          n_errors;

	csr_unit dut (.*);

	always #10 i_clk = ~i_clk; // 20 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Zicsr word in register form with rd = x1
	function automatic logic [31:0] csr_word(input logic [1:0] op, input csr_addr_t addr,
		input logic [4:0] rs1);
		return {addr, rs1, 1'b0, op, 5'd1, 7'h73};
	endfunction

	// Expected mstatus with MPP always M
	function automatic xlen_t mstatus_val(input logic mie, input logic mpie);
		return (xlen_t'(PRIV_M) << MSTATUS_MPP) | (xlen_t'(mpie) << MSTATUS_MPIE) |
			(xlen_t'(mie) << MSTATUS_MIE);
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report(input string name, input int errs_before);
		if (n_errors == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d mismatches", name, n_errors - errs_before);
	endtask

	// One pipeline cycle with outputs looked at mid low phase
	task automatic drive(input logic en, input logic [31:0] inst, input xlen_t wd,
		input logic [3:0] faults, input xlen_t badaddr, input xlen_t pc);
		@(negedge i_clk);
		i_csr_en  = en;
		i_inst    = inst;
		i_wd      = wd;
		i_pc      = pc;
		i_badaddr = badaddr;
		i_int_tip = tip_level;
		{i_ex_inst_addr, i_illegal, i_ex_ld_addr, i_ex_st_addr} = faults; // Priority order
		#5;
	endtask

	task automatic issue_csr(input csr_op_e op, input csr_addr_t addr, input xlen_t wd);
		// rs1 = x0 only for pure reads
		drive(1'b1, csr_word(op, addr, (op == CSR_RW || wd != 0) ? 5'd5 : 5'd0), wd,
			4'b0, '0, i_pc);
	endtask

	task automatic issue_sys(input csr_addr_t f12, input xlen_t pc);
		drive(1'b1, {f12, 5'd0, F3_PRIV, 5'd0, 7'h73}, '0, 4'b0, '0, pc);
	endtask

	// CSRRS with x0 reads without side effect
	task automatic expect_csr(input csr_addr_t addr, input xlen_t exp, input string what);
		issue_csr(CSR_RS, addr, '0);
		check(what, o_rd, exp);
	endtask

	task automatic test_reset_state();
		int e0;
		e0 = n_errors;
		expect_csr(ADDR_MHARTID, HART_ID, "mhartid");
		check("o_ex after reset", o_ex, 1'b0);
		expect_csr(ADDR_MISA, MISA_VALUE, "misa");
		expect_csr(ADDR_MSTATUS, mstatus_val(1'b0, 1'b0), "mstatus after reset");
		expect_csr(ADDR_MCAUSE, '0, "mcause after reset");
		check("o_cause after reset", o_cause, '0);
		check("o_ex idle", o_ex, 1'b0);
		check("o_eret idle", o_eret, 1'b0);
		issue_csr(CSR_RW, ADDR_MISA, next_rand()); // Read only so it traps
		check("o_ex on misa write", o_ex, 1'b1);
		expect_csr(ADDR_MCAUSE, xlen_t'(CAUSE_ILLEGAL), "mcause after misa write");
		check("o_cause after misa write", o_cause, xlen_t'(CAUSE_ILLEGAL));
		report("reset_state", e0);
	endtask

	task automatic test_csr_ops();
		int    e0;
		xlen_t a;
		xlen_t b;
		xlen_t c;
		xlen_t v;
		e0 = n_errors;
		a = next_rand();
		b = next_rand();
		c = next_rand();
		issue_csr(CSR_RW, ADDR_MSCRATCH, a);
		expect_csr(ADDR_MSCRATCH, a, "mscratch after RW");
		issue_csr(CSR_RS, ADDR_MSCRATCH, b);
		check("RS returns old value", o_rd, a);
		expect_csr(ADDR_MSCRATCH, a | b, "mscratch after RS");
		issue_csr(CSR_RC, ADDR_MSCRATCH, c);
		expect_csr(ADDR_MSCRATCH, (a | b) & ~c, "mscratch after RC");
		v = next_rand();
		issue_csr(CSR_RW, ADDR_MTVEC, v);
		expect_csr(ADDR_MTVEC, v & ~xlen_t'(3), "mtvec aligned");
		check("o_tvec follows mtvec", o_tvec, v & ~xlen_t'(3));
		v = next_rand();
		issue_csr(CSR_RW, ADDR_MEPC, v);
		expect_csr(ADDR_MEPC, v & ~xlen_t'(3), "mepc aligned");
		report("csr_ops", e0);
	endtask

	task automatic test_ecall_ebreak();
		int    e0;
		xlen_t tvec;
		xlen_t pc;
		e0 = n_errors;
		tvec = next_rand() & ~xlen_t'(3);
		issue_csr(CSR_RW, ADDR_MTVEC, tvec);
		for (int k = 0; k < 2; k++) begin // ECALL then EBREAK
			pc = next_rand() & ~xlen_t'(3);
			issue_csr(CSR_RW, ADDR_MSTATUS, mstatus_val(1'b1, 1'b0));
			issue_sys(k[0] ? F12_EBREAK : F12_ECALL, pc);
			check("o_ex on system call", o_ex, 1'b1);
			check("o_tvec on system call", o_tvec, tvec);
			expect_csr(ADDR_MCAUSE, k[0] ? CAUSE_BREAKPOINT : CAUSE_ECALL_M, "mcause");
			check("o_cause", o_cause, k[0] ? CAUSE_BREAKPOINT : CAUSE_ECALL_M);
			expect_csr(ADDR_MTVAL, k[0] ? pc : '0, "mtval");
			expect_csr(ADDR_MEPC, pc, "mepc");
			expect_csr(ADDR_MSTATUS, mstatus_val(1'b0, 1'b1), "mstatus pushed");
		end
		report("ecall_ebreak", e0);
	endtask

	task automatic test_mret();
		int    e0;
		xlen_t epc;
		e0 = n_errors;
		for (int k = 0; k < 2; k++) begin
			epc = next_rand() & ~xlen_t'(3);
			issue_csr(CSR_RW, ADDR_MEPC, epc);
			issue_csr(CSR_RW, ADDR_MSTATUS, mstatus_val(k[0], !k[0])); // MPIE opposite MIE
			issue_sys(ADDR_MRET, i_pc);
			check("o_eret", o_eret, 1'b1);
			check("o_epc", o_epc, epc);
			check("no trap on MRET", o_ex, 1'b0);
			expect_csr(ADDR_MSTATUS, mstatus_val(!k[0], 1'b1), "mstatus popped");
		end
		report("mret", e0);
	endtask

	task automatic test_priority();
		int          e0;
		logic [4:0]  r;      // {bad csr, inst, illegal, load, store}
		xlen_t       keep;
		xlen_t       bad;
		xlen_t       exp_tval;
		cause_t      exp_cause;
		logic [31:0] inst;
		e0 = n_errors;
		keep = next_rand();
		issue_csr(CSR_RW, ADDR_MSCRATCH, keep);
		repeat (8) begin
			r = 5'(next_rand());
			if (r == 5'd0)
				r[0] = 1'b1; // Always at least one fault
			bad  = next_rand();
			inst = csr_word(CSR_RW, r[4] ? 12'h7C0 : ADDR_MSCRATCH, 5'd5);
			drive(1'b1, inst, next_rand(), r[3:0], bad, i_pc);
			exp_tval = bad;
			if (r[3])
				exp_cause = CAUSE_INST_MISALIGN;
			else if (r[2] || r[4]) begin
				exp_cause = CAUSE_ILLEGAL;
				exp_tval  = inst;
			end else if (r[1])
				exp_cause = CAUSE_LOAD_MISALIGN;
			else
				exp_cause = CAUSE_STORE_MISALIGN;
			check("o_ex on fault", o_ex, 1'b1);
			expect_csr(ADDR_MCAUSE, exp_cause, "mcause priority");
			expect_csr(ADDR_MTVAL, exp_tval, "mtval on fault");
			expect_csr(ADDR_MSCRATCH, keep, "mscratch write suppressed");
		end
		report("priority", e0);
	endtask

	task automatic test_timer();
		int    e0;
		xlen_t pc;
		xlen_t tval;
		e0 = n_errors;
		tip_level = 1'b0;
		issue_csr(CSR_RW, ADDR_MSTATUS, '0);
		issue_csr(CSR_RW, ADDR_MIE, '0);
		tval = next_rand();
		issue_csr(CSR_RW, ADDR_MTVAL, tval); // Known mtval before the interrupt
		expect_csr(ADDR_MIP, '0, "mip idle");
		tip_level = 1'b1;
		expect_csr(ADDR_MIP, xlen_t'(1) << MIX_MT, "mip pending");
		check("no trap, MIE and MTIE clear", o_ex, 1'b0);
		issue_csr(CSR_RW, ADDR_MIE, xlen_t'(1) << MIX_MT);
		expect_csr(ADDR_MIE, xlen_t'(1) << MIX_MT, "mie MTIE");
		check("no trap, MIE clear", o_ex, 1'b0);
		issue_csr(CSR_RW, ADDR_MIE, '0);
		issue_csr(CSR_RW, ADDR_MSTATUS, mstatus_val(1'b1, 1'b0));
		expect_csr(ADDR_MSTATUS, mstatus_val(1'b1, 1'b0), "mstatus MIE");
		check("no trap, MTIE clear", o_ex, 1'b0);
		issue_csr(CSR_RW, ADDR_MIE, xlen_t'(1) << MIX_MT); // Old MTIE still 0 here
		pc = next_rand() & ~xlen_t'(3);
		drive(1'b0, '0, '0, 4'b0, '0, pc); // Plain instruction lets the interrupt in
		check("o_ex on timer", o_ex, 1'b1);
		tip_level = 1'b0;
		expect_csr(ADDR_MCAUSE, (xlen_t'(1) << (XLEN - 1)) | CAUSE_TIMER_INT, "mcause int");
		check("o_cause int", o_cause, (xlen_t'(1) << (XLEN - 1)) | CAUSE_TIMER_INT);
		expect_csr(ADDR_MEPC, pc + 4, "mepc after interrupt");
		expect_csr(ADDR_MTVAL, tval, "mtval kept on interrupt");
		expect_csr(ADDR_MSTATUS, mstatus_val(1'b0, 1'b1), "mstatus after interrupt");
		// ECALL and pending timer together
		issue_csr(CSR_RW, ADDR_MSTATUS, mstatus_val(1'b1, 1'b0));
		tip_level = 1'b1;
		issue_sys(F12_ECALL, pc);
		check("o_ex on ECALL with timer", o_ex, 1'b1);
		expect_csr(ADDR_MCAUSE, xlen_t'(CAUSE_ECALL_M), "exception over interrupt");
		expect_csr(ADDR_MEPC, pc, "mepc on exception");
		tip_level = 1'b0;
		report("timer", e0);
	endtask

	initial begin
		i_clk          = 1'b0;
		i_rst          = 1'b0; // Held for 4 cycles
		i_csr_en       = 1'b0;
		i_wd           = '0;
		i_inst         = '0;
		i_pc           = '0;
		i_badaddr      = '0;
		i_illegal      = 1'b0;
		i_ex_inst_addr = 1'b0;
		i_ex_ld_addr   = 1'b0;
		i_ex_st_addr   = 1'b0;
		i_int_tip      = 1'b0;
		tip_level      = 1'b0;
		rng            = 32'hbd61_3f4d;
		n_checks       = 0;
		n_errors       = 0;
		repeat (4) @(negedge i_clk);
		i_rst = 1'b1;
		test_reset_state();
		test_csr_ops();
		test_ecall_ebreak();
		test_mret();
		test_priority();
		test_timer();
		$display("Summary: %0d checks, %0d mismatches", n_checks, n_errors);
		if (n_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog of 200 cycles per test plus margin
	initial begin
		repeat (NUM_TESTS * 200 + 50) @(posedge i_clk);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Test failures found");
		$finish;
	end

endmodule

/* csr_trap_ctrl.sv */
`timescale 1ns/1ps

module csr_trap_ctrl (
	input  logic                i_is_ecall,
	input  logic                i_is_ebreak,
	input  logic                i_illegal_csr,  // From csr_decode
	input  logic                i_illegal,      // From main decoder
	input  logic                i_ex_inst_addr, // Instruction misaligned
	input  logic                i_ex_ld_addr,   // Load misaligned
	input  logic                i_ex_st_addr,   // Store misaligned
	input  logic                i_int_tip,      // Timer pending
	input  logic                i_mstatus_mie,
	input  logic                i_mtie,
	input  csr_pkg::xlen_t      i_pc,
	input  csr_pkg::xlen_t      i_badaddr,
	input  logic [31:0]         i_inst,
	output logic                o_trap,
	output logic                o_trap_int,
	output logic                o_sync_ex,
	output csr_pkg::cause_t     o_trap_cause,
	output csr_pkg::xlen_t      o_trap_tval,
	output logic                o_tval_we,      // Low keeps mtval
	output csr_pkg::xlen_t      o_trap_epc
);
	import csr_pkg::*;

	logic illegal;
	logic int_ti; // Timer interrupt enabled and pending

	assign illegal = i_illegal || i_illegal_csr;

	// Any synchronous exception
	assign o_sync_ex = i_ex_inst_addr || illegal || i_is_ecall || i_is_ebreak ||
		i_ex_ld_addr || i_ex_st_addr;

	assign int_ti     = i_mstatus_mie && i_mtie && i_int_tip;
	assign o_trap_int = int_ti && !o_sync_ex; // Exceptions win
	assign o_trap     = o_sync_ex || o_trap_int;

	// Fixed priority where the first match picks cause and tval
	always_comb begin
		o_trap_cause = CAUSE_INST_MISALIGN;
		o_trap_tval  = '0;
		o_tval_we    = 1'b0;
		o_trap_epc   = i_pc; // Faulting instruction
		if (i_ex_inst_addr) begin
			o_trap_cause = CAUSE_INST_MISALIGN;
			o_trap_tval  = i_badaddr;
			o_tval_we    = 1'b1;
		end else if (illegal) begin
			o_trap_cause = CAUSE_ILLEGAL;
			o_trap_tval  = xlen_t'(i_inst); // Offending word
			o_tval_we    = 1'b1;
		end else if (i_is_ecall) begin
			o_trap_cause = CAUSE_ECALL_M;
			o_trap_tval  = '0;
			o_tval_we    = 1'b1;
		end else if (i_is_ebreak) begin
			o_trap_cause = CAUSE_BREAKPOINT;
			o_trap_tval  = i_pc;
			o_tval_we    = 1'b1;
		end else if (i_ex_ld_addr) begin
			o_trap_cause = CAUSE_LOAD_MISALIGN;
			o_trap_tval  = i_badaddr;
			o_tval_we    = 1'b1;
		end else if (i_ex_st_addr) begin
			o_trap_cause = CAUSE_STORE_MISALIGN;
			o_trap_tval  = i_badaddr;
			o_tval_we    = 1'b1;
		end else if (o_trap_int) begin
			// Current instruction retires so resume after it
			o_trap_cause = CAUSE_TIMER_INT;
			o_trap_epc   = i_pc + xlen_t'(4);
		end
	end

endmodule

/* csr_unit.sv */
`timescale 1ns/1ps

module csr_unit (
	input  logic            i_clk,
	input  logic            i_rst,          // Sync, active low
	input  logic            i_csr_en,       // CSR enable from pipeline
	input  csr_pkg::xlen_t  i_wd,
	input  logic [31:0]     i_inst,
	input  csr_pkg::xlen_t  i_pc,
	input  csr_pkg::xlen_t  i_badaddr,
	input  logic            i_illegal,
	input  logic            i_ex_inst_addr,
	input  logic            i_ex_ld_addr,
	input  logic            i_ex_st_addr,
	input  logic            i_int_tip,
	output csr_pkg::xlen_t  o_rd,
	output logic            o_ex,           // Trap taken this cycle
	output csr_pkg::xlen_t  o_tvec,
	output csr_pkg::xlen_t  o_cause,
	output logic            o_eret,
	output csr_pkg::xlen_t  o_epc
);
	import csr_pkg::*;

	// Decode results
	logic      csr_access;
	csr_op_e   csr_op;
	csr_addr_t csr_addr;
	logic      is_ecall;
	logic      is_ebreak;
	logic      is_mret;
	logic      illegal_csr;

	// Trap decision
	logic      trap_int;
	logic      sync_ex;
	cause_t    trap_cause;
	xlen_t     trap_tval;
	logic      tval_we;
	xlen_t     trap_epc;

	// Enable bits back from the regfile
	logic      mstatus_mie;
	logic      mtie;

	csr_decode u_decode (
		.i_csr_en      (i_csr_en),
		.i_inst        (i_inst),
		.o_csr_access  (csr_access),
		.o_csr_op      (csr_op),
		.o_csr_addr    (csr_addr),
		.o_is_ecall    (is_ecall),
		.o_is_ebreak   (is_ebreak),
		.o_is_mret     (is_mret),
		.o_illegal_csr (illegal_csr)
	);

	csr_trap_ctrl u_trap_ctrl (
		.i_is_ecall     (is_ecall),
		.i_is_ebreak    (is_ebreak),
		.i_illegal_csr  (illegal_csr),
		.i_illegal      (i_illegal),
		.i_ex_inst_addr (i_ex_inst_addr),
		.i_ex_ld_addr   (i_ex_ld_addr),
		.i_ex_st_addr   (i_ex_st_addr),
		.i_int_tip      (i_int_tip),
		.i_mstatus_mie  (mstatus_mie),
		.i_mtie         (mtie),
		.i_pc           (i_pc),
		.i_badaddr      (i_badaddr),
		.i_inst         (i_inst),
		.o_trap         (o_ex),
		.o_trap_int     (trap_int),
		.o_sync_ex      (sync_ex),
		.o_trap_cause   (trap_cause),
		.o_trap_tval    (trap_tval),
		.o_tval_we      (tval_we),
		.o_trap_epc     (trap_epc)
	);

	csr_regfile u_regfile (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_csr_access   (csr_access),
		.i_csr_op       (csr_op),
		.i_csr_addr     (csr_addr),
		.i_wd           (i_wd),
		.i_is_mret      (is_mret),
		.i_int_tip      (i_int_tip),
		.i_trap         (o_ex),
		.i_trap_int     (trap_int),
		.i_sync_ex      (sync_ex),
		.i_trap_cause   (trap_cause),
		.i_trap_tval    (trap_tval),
		.i_tval_we      (tval_we),
		.i_trap_epc     (trap_epc),
		.o_rd           (o_rd),
		.o_mstatus_mie  (mstatus_mie),
		.o_mtie         (mtie),
		.o_tvec         (o_tvec),
		.o_cause        (o_cause),
		.o_eret         (o_eret),
		.o_epc          (o_epc)
	);

endmodule

/* flist.f */
csr_pkg.sv
csr_decode.sv
csr_trap_ctrl.sv
csr_regfile.sv
csr_unit.sv
csr_tb.sv
